// File: common/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  typedef enum logic [1:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } core_state_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    CLASS_ALU_REG,
    CLASS_ALU_IMM,
    CLASS_LUI,
    CLASS_BRANCH,
    CLASS_JAL,
    CLASS_JALR,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_NOP
  } instr_class_e;

  typedef enum logic [1:0] {
    FETCH_OWNER,
    LSU_OWNER,
    EXT_OWNER
  } bus_owner_e;

  // rv32i major opcode groups
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;

endpackage

`default_nettype wire

// File: hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
  import rv_core_pkg::*;
(
  input  wire [31:0]   instr_i,
  output logic [4:0]   rs1_addr_o,
  output logic [4:0]   rs2_addr_o,
  output logic [4:0]   rd_addr_o,
  output logic [31:0]  imm_o,
  output alu_op_e      alu_op_o,
  output instr_class_e class_o,
  output logic [2:0]   funct3_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];
  assign funct3_o   = funct3;

  // shared by register and immediate forms
  function automatic alu_op_e op_of_funct3(input logic [2:0] f3);
    case (f3)
      3'b111:  return ALU_AND;
      3'b110:  return ALU_OR;
      3'b100:  return ALU_XOR;
      3'b010:  return ALU_SLT;
      3'b001:  return ALU_SLL;
      3'b101:  return ALU_SRL;
      default: return ALU_ADD;
    endcase
  endfunction

  always_comb begin
    imm_o    = {{20{instr_i[31]}}, instr_i[31:20]};
    alu_op_o = ALU_ADD;
    class_o  = CLASS_NOP;
    case (opcode)
      OPC_REG: begin
        alu_op_o = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : op_of_funct3(funct3);
        if (funct3 != 3'b011 &&
            (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000)))
          class_o = CLASS_ALU_REG;
      end
      OPC_IMM: begin
        alu_op_o = op_of_funct3(funct3);
        // shift immediates only valid with a zero upper field, no sra
        if (funct3 != 3'b011 && (funct3[1:0] != 2'b01 || funct7 == 7'b0))
          class_o = CLASS_ALU_IMM;
      end
      OPC_LUI: begin
        imm_o    = {instr_i[31:12], 12'b0};
        alu_op_o = ALU_PASS_B;
        class_o  = CLASS_LUI;
      end
      OPC_BRANCH: begin
        imm_o    = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
        alu_op_o = ALU_SUB;
        if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b100 || funct3 == 3'b101)
          class_o = CLASS_BRANCH;
      end
      OPC_JAL: begin
        imm_o   = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};
        class_o = CLASS_JAL;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000)
          class_o = CLASS_JALR;
      end
      OPC_LOAD: begin
        // lb, lw, lbu
        if (funct3 == 3'b000 || funct3 == 3'b010 || funct3 == 3'b100)
          class_o = CLASS_LOAD;
      end
      OPC_STORE: begin
        imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        if (funct3 == 3'b000 || funct3 == 3'b010)
          class_o = CLASS_STORE;
      end
      default: begin
        class_o = CLASS_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire         clk_i,
  input  wire         we_i,
  input  wire  [4:0]  rd_addr_i,
  input  wire  [31:0] rd_data_i,
  input  wire  [4:0]  rs1_addr_i,
  input  wire  [4:0]  rs2_addr_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && rd_addr_i != 5'd0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'h0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'h0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_core_pkg::*;
(
  input  wire alu_op_e op_i,
  input  wire [31:0]   a_i,
  input  wire [31:0]   b_i,
  output logic [31:0]  result_o,
  output logic         equal_o,
  output logic         less_o
);

  logic [4:0] shamt;

  assign shamt   = b_i[4:0];
  assign equal_o = (a_i == b_i);
  // signed compare, shared by slt and branches
  assign less_o  = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = {31'b0, less_o};
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bus_arbiter
  import rv_core_pkg::*;
(
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire         fetch_req_i,
  input  wire         lsu_req_i,
  input  wire         ext_req_i,
  input  wire  [29:0] fetch_adr_i,
  input  wire  [29:0] lsu_adr_i,
  input  wire  [3:0]  lsu_sel_i,
  input  wire         lsu_we_i,
  input  wire         lsu_stb_i,
  input  wire         fetch_stb_i,
  output bus_owner_e  owner_o,
  output logic        ext_grant_o,
  output logic [29:0] adr_o,
  output logic [3:0]  sel_o,
  output logic        we_o,
  output logic        stb_o
);

  bus_owner_e pick;
  logic       owner_req;

  // lsu first, then fetch, then external; idle falls back to fetch
  always_comb begin
    if (lsu_req_i)       pick = LSU_OWNER;
    else if (fetch_req_i) pick = FETCH_OWNER;
    else if (ext_req_i)   pick = EXT_OWNER;
    else                  pick = FETCH_OWNER;
  end

  always_comb begin
    case (owner_o)
      LSU_OWNER: owner_req = lsu_req_i;
      EXT_OWNER: owner_req = ext_req_i;
      default:   owner_req = fetch_req_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_o <= FETCH_OWNER;
    end else if (!owner_req) begin
      owner_o <= pick;
    end
  end

  assign ext_grant_o = (owner_o == EXT_OWNER);
  assign adr_o = (owner_o == LSU_OWNER) ? lsu_adr_i : fetch_adr_i;
  assign sel_o = (owner_o == LSU_OWNER) ? lsu_sel_i : 4'b1111;
  assign we_o  = (owner_o == LSU_OWNER) && lsu_we_i;
  assign stb_o = (owner_o == LSU_OWNER) ? lsu_stb_i :
                 (owner_o == FETCH_OWNER) ? fetch_stb_i : 1'b0;

endmodule

`default_nettype wire

// File: hw/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire         [31:0] addr_i,
  input  wire         [31:0] store_data_i,
  input  wire                byte_i,
  input  wire                unsigned_i,
  input  wire         [31:0] bus_data_i,
  output logic        [29:0] word_adr_o,
  output logic        [3:0]  sel_o,
  output logic        [31:0] store_data_o,
  output logic        [31:0] load_data_o
);

  logic [1:0] lane;
  logic [7:0] load_byte;

  assign lane       = addr_i[1:0];
  assign word_adr_o = addr_i[31:2];

  always_comb begin
    if (byte_i) begin
      sel_o        = 4'b0001 << lane;
      store_data_o = {4{store_data_i[7:0]}};
    end else begin
      sel_o        = 4'b1111;
      store_data_o = store_data_i;
    end
  end

  // pick the addressed lane
  always_comb begin
    case (lane)
      2'd0:    load_byte = bus_data_i[7:0];
      2'd1:    load_byte = bus_data_i[15:8];
      2'd2:    load_byte = bus_data_i[23:16];
      default: load_byte = bus_data_i[31:24];
    endcase
  end

  always_comb begin
    if (!byte_i) begin
      load_data_o = bus_data_i;
    end else if (unsigned_i) begin
      load_data_o = {24'b0, load_byte};
    end else begin
      load_data_o = {{24{load_byte[7]}}, load_byte};
    end
  end

endmodule

`default_nettype wire

// File: rv_core/rv_core_nopipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_nopipe
  import rv_core_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire  [31:0] master_dat_i,
  input  wire         ack_i,
  input  wire         ctrl_req_i,
  output logic [31:0] master_dat_o,
  output logic [29:0] adr_o,
  output logic [3:0]  sel_o,
  output logic        stb_o,
  output logic        we_o,
  output logic        ctrl_grant_o,
  output logic [13:0] debug_o
);

  core_state_e  state;
  bus_owner_e   owner;
  instr_class_e cls;
  alu_op_e      alu_op;
  logic [31:0]  pc_q, pc_next_q, instr_q, result_q, pc_next, pc_plus4;
  logic [31:0]  imm, rs1_data, rs2_data, alu_b, alu_result, load_data, lsu_dat;
  logic [4:0]   rs1_addr, rs2_addr, rd_addr;
  logic [2:0]   funct3;
  logic [29:0]  lsu_adr;
  logic [3:0]   lsu_sel;
  logic         alu_equal, alu_less, taken, rd_we, is_mem, is_link;
  logic         fetch_req, lsu_req, fetch_stb, lsu_stb;

  assign fetch_req = (state == FETCH);
  assign lsu_req   = (state == MEMORY);
  // strobe only once the arbiter has handed over the bus and reset is released
  assign fetch_stb = fetch_req && (owner == FETCH_OWNER) && !reset_i;
  assign lsu_stb   = lsu_req && (owner == LSU_OWNER);

  assign is_mem  = (cls == CLASS_LOAD) || (cls == CLASS_STORE);
  assign is_link = (cls == CLASS_JAL) || (cls == CLASS_JALR);
  assign alu_b   = (cls == CLASS_ALU_REG || cls == CLASS_BRANCH) ? rs2_data : imm;
  assign rd_we   = (state == WRITEBACK) && (rd_addr != 5'd0) && (cls != CLASS_BRANCH) &&
                   (cls != CLASS_STORE) && (cls != CLASS_NOP);

  always_comb begin
    case (funct3)
      3'b000:  taken = alu_equal;
      3'b001:  taken = !alu_equal;
      3'b100:  taken = alu_less;
      default: taken = !alu_less;
    endcase
  end

  assign pc_plus4 = pc_q + 32'd4;
  assign pc_next  = (cls == CLASS_JALR) ? {alu_result[31:1], 1'b0} :
                    (cls == CLASS_JAL || (cls == CLASS_BRANCH && taken)) ? pc_q + imm :
                    pc_plus4;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= FETCH;
      pc_q  <= RESET_PC;
    end else begin
      case (state)
        FETCH:     if (fetch_stb && ack_i) state <= EXECUTE;
        EXECUTE:   state <= is_mem ? MEMORY : WRITEBACK;
        MEMORY:    if (lsu_stb && ack_i) state <= WRITEBACK;
        default: begin
          pc_q  <= pc_next_q;
          state <= FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == FETCH && fetch_stb && ack_i) instr_q <= master_dat_i;
    if (state == EXECUTE) begin
      result_q  <= is_link ? pc_plus4 : alu_result;
      pc_next_q <= pc_next;
    end
    if (state == MEMORY && lsu_stb && ack_i && cls == CLASS_LOAD) result_q <= load_data;
  end

  assign master_dat_o = lsu_dat;
  assign debug_o      = pc_q[15:2];

  rv_decode u_decode (.instr_i(instr_q), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rd_addr_o(rd_addr), .imm_o(imm), .alu_op_o(alu_op), .class_o(cls), .funct3_o(funct3));

  rv_regfile u_regfile (.clk_i(clk_i), .we_i(rd_we), .rd_addr_i(rd_addr),
    .rd_data_i(result_q), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

  rv_alu u_alu (.op_i(alu_op), .a_i(rs1_data), .b_i(alu_b), .result_o(alu_result),
    .equal_o(alu_equal), .less_o(alu_less));

  rv_lsu u_lsu (.addr_i(alu_result), .store_data_i(rs2_data), .byte_i(funct3[1:0] == 2'b00),
    .unsigned_i(funct3[2]), .bus_data_i(master_dat_i), .word_adr_o(lsu_adr),
    .sel_o(lsu_sel), .store_data_o(lsu_dat), .load_data_o(load_data));

  rv_bus_arbiter u_arbiter (.clk_i(clk_i), .reset_i(reset_i), .fetch_req_i(fetch_req),
    .lsu_req_i(lsu_req), .ext_req_i(ctrl_req_i), .fetch_adr_i(pc_q[31:2]),
    .lsu_adr_i(lsu_adr), .lsu_sel_i(lsu_sel), .lsu_we_i(cls == CLASS_STORE),
    .lsu_stb_i(lsu_stb), .fetch_stb_i(fetch_stb), .owner_o(owner),
    .ext_grant_o(ctrl_grant_o), .adr_o(adr_o), .sel_o(sel_o), .we_o(we_o), .stb_o(stb_o));

endmodule

`default_nettype wire

// File: tb/tb_bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_memory (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire  [29:0] adr_i,
  input  wire  [31:0] dat_i,
  input  wire  [3:0]  sel_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire         ctrl_grant_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        ctrl_req_o
);

  logic [31:0] mem [0:2047];
  logic [31:0] lfsr;
  logic [31:0] rdata;
  logic [1:0]  wait_left;
  logic        busy;
  logic        marker_hit;
  logic        stb_during_grant;
  logic        ext_granted;

  // fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_delay();
    lfsr = lfsr_next(lfsr);
    wait_left[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    wait_left[1] = lfsr[0];
  endtask

  initial begin
    lfsr = 32'h6cea_2dd0;
    dat_o = 32'h0;
    ack_o = 1'b0;
    ctrl_req_o = 1'b0;
    busy = 1'b0;
    wait_left = 2'd0;
    marker_hit = 1'b0;
    stb_during_grant = 1'b0;
    ext_granted = 1'b0;
  end

  // inputs are sampled before the DUT registers update, outputs move 1 ns later
  always begin
    @(posedge clk_i);
    if (ctrl_grant_i && stb_i) stb_during_grant = 1'b1;
    if (reset_i || ack_o) begin
      busy = 1'b0;
      if (reset_i) marker_hit = 1'b0;
      #1 ack_o = 1'b0;
    end else if (stb_i) begin
      if (!busy) begin
        busy = 1'b1;
        pick_delay();
      end
      if (wait_left == 2'd0) begin
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) mem[adr_i[10:0]][8*b +: 8] = dat_i[8*b +: 8];
          end
          if (adr_i == 30'h100) marker_hit = 1'b1;
        end
        rdata = mem[adr_i[10:0]];
        #1;
        dat_o = rdata;
        ack_o = 1'b1;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  // acts as the external master for one word write
  task automatic ext_write(input logic [29:0] adr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk_i);
    #1 ctrl_req_o = 1'b1;
    do begin
      @(posedge clk_i);
      n++;
    end while (!ctrl_grant_i && n < 200);
    if (ctrl_grant_i) begin
      mem[adr[10:0]] = data;
      ext_granted = 1'b1;
    end
    #1 ctrl_req_o = 1'b0;
  endtask

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  logic        clk;
  logic        reset;
  wire  [31:0] mem_dat, core_dat;
  wire  [29:0] adr;
  wire  [3:0]  sel;
  wire         stb, we, ack, ctrl_req, ctrl_grant;
  wire  [13:0] debug;
  wire  [29:0] alt_adr;
  wire         alt_stb, alt_we, alt_grant;
  wire  [13:0] alt_debug;

  logic [31:0] prog [$];
  logic [31:0] expect_q [$];
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  rv_core_nopipe dut0 (.clk_i(clk), .reset_i(reset), .master_dat_i(mem_dat), .ack_i(ack),
    .ctrl_req_i(ctrl_req), .master_dat_o(core_dat), .adr_o(adr), .sel_o(sel), .stb_o(stb),
    .we_o(we), .ctrl_grant_o(ctrl_grant), .debug_o(debug));

  // second core only shows where a non-zero reset pc starts fetching
  rv_core_nopipe #(.RESET_PC(32'h40)) dut_alt (.clk_i(clk), .reset_i(reset),
    .master_dat_i(32'h0), .ack_i(1'b0), .ctrl_req_i(1'b0), .master_dat_o(),
    .adr_o(alt_adr), .sel_o(), .stb_o(alt_stb), .we_o(alt_we),
    .ctrl_grant_o(alt_grant), .debug_o(alt_debug));

  tb_bus_memory mem0 (.clk_i(clk), .reset_i(reset), .adr_i(adr), .dat_i(core_dat),
    .sel_i(sel), .stb_i(stb), .we_i(we), .ctrl_grant_i(ctrl_grant), .dat_o(mem_dat),
    .ack_o(ack), .ctrl_req_o(ctrl_req));

  always #2 clk = ~clk;

  initial begin
    #(6 * 400 * 4);
    $display("watchdog timeout: the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic clear_memory();
    for (int i = 0; i < 2048; i++) mem0.mem[i] = 32'h0;
    prog.delete();
    expect_q.delete();
  endtask

  // instruction, then a word store of its rd into the next result slot
  task automatic store_result(input logic [31:0] instr, input logic [31:0] exp);
    prog.push_back(instr);
    prog.push_back(s_type(12'h200 + 12'(4 * expect_q.size()), instr[11:7], 3'b010));
    expect_q.push_back(exp);
  endtask

  task automatic end_program();
    prog.push_back(s_type(12'h400, 5'd0, 3'b010));
    prog.push_back(j_type(21'd0, 5'd0));
    foreach (prog[i]) mem0.mem[i] = prog[i];
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic run_until_marker(input string name);
    int n;
    n = 0;
    pulse_reset();
    while (!mem0.marker_hit && n < 600) begin
      @(posedge clk);
      n++;
    end
    if (!mem0.marker_hit) begin
      $display("%s: program never reached its end marker", name);
      test_errors++;
    end
  endtask

  task automatic check_results(input string name);
    foreach (expect_q[k]) check_word(name, expect_q[k], mem0.mem[12'h80 + k]);
  endtask

  task automatic build_alu_program();
    int          a;
    int          b;
    logic [31:0] bu;
    a = 100;
    b = -7;
    bu = b;
    clear_memory();
    prog.push_back(addi(5'd1, 5'd0, 12'd100));
    prog.push_back(addi(5'd2, 5'd0, -12'sd7));
    prog.push_back(addi(5'd10, 5'd0, 12'd3));
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
    store_result(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
    store_result(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), (b < a) ? 1 : 0);
    store_result(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), (a < b) ? 1 : 0);
    store_result(r_type(7'h00, 5'd10, 5'd1, 3'b001, 5'd3), a << 3);
    store_result(r_type(7'h00, 5'd10, 5'd2, 3'b101, 5'd3), bu >> 3);
    store_result(addi(5'd3, 5'd1, -12'sd200), a - 200);
    store_result(i_type(12'h0f0, 5'd2, 3'b111, 5'd3, 7'b0010011), bu & 32'hf0);
    store_result(i_type(12'h700, 5'd1, 3'b110, 5'd3, 7'b0010011), a | 32'h700);
    store_result(i_type(12'hfff, 5'd2, 3'b100, 5'd3, 7'b0010011), ~bu);
    store_result(i_type(-12'sd8, 5'd2, 3'b010, 5'd3, 7'b0010011), (b < -8) ? 1 : 0);
    store_result(i_type(-12'sd6, 5'd2, 3'b010, 5'd3, 7'b0010011), (b < -6) ? 1 : 0);
    store_result(i_type(12'd4, 5'd2, 3'b001, 5'd3, 7'b0010011), bu << 4);
    store_result(i_type(12'd28, 5'd2, 3'b101, 5'd3, 7'b0010011), bu >> 28);
    store_result({20'habcde, 5'd3, 7'b0110111}, 32'habcde000);
    end_program();
  endtask

  task automatic alu_test();
    build_alu_program();
    run_until_marker("alu");
    check_results("alu");
    finish_test("alu");
  endtask

  // branch over one store; the slot stays zero when the branch is taken
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input int va, input int vb);
    logic taken;
    case (f3)
      3'b000:  taken = (va == vb);
      3'b001:  taken = (va != vb);
      3'b100:  taken = (va < vb);
      default: taken = (va >= vb);
    endcase
    prog.push_back(b_type(13'd8, rs2, rs1, f3));
    prog.push_back(s_type(12'h200 + 12'(4 * expect_q.size()), 5'd3, 3'b010));
    expect_q.push_back(taken ? 32'd0 : 32'd1);
  endtask

  task automatic branch_test();
    clear_memory();
    prog.push_back(addi(5'd1, 5'd0, 12'd5));
    prog.push_back(addi(5'd2, 5'd0, -12'sd3));
    prog.push_back(addi(5'd3, 5'd0, 12'd1));
    branch_case(3'b000, 5'd1, 5'd1, 5, 5);
    branch_case(3'b000, 5'd1, 5'd2, 5, -3);
    branch_case(3'b001, 5'd1, 5'd2, 5, -3);
    branch_case(3'b001, 5'd1, 5'd1, 5, 5);
    branch_case(3'b100, 5'd2, 5'd1, -3, 5);
    branch_case(3'b100, 5'd1, 5'd2, 5, -3);
    branch_case(3'b101, 5'd1, 5'd2, 5, -3);
    branch_case(3'b101, 5'd2, 5'd1, -3, 5);
    branch_case(3'b101, 5'd1, 5'd1, 5, 5);
    end_program();
    run_until_marker("branch");
    check_results("branch");
    finish_test("branch");
  endtask

  task automatic jump_test();
    int jal_at;
    int jalr_at;
    int loop_at;
    clear_memory();
    prog.push_back(addi(5'd9, 5'd0, 12'd0));
    jal_at = prog.size() * 4;
    prog.push_back(j_type(21'd12, 5'd1));
    prog.push_back(addi(5'd9, 5'd0, 12'd99));
    prog.push_back(addi(5'd9, 5'd0, 12'd99));
    prog.push_back(s_type(12'h200, 5'd1, 3'b010));
    // target 36; the odd sum checks that bit 0 is cleared
    prog.push_back(addi(5'd2, 5'd0, 12'd35));
    jalr_at = prog.size() * 4;
    prog.push_back(i_type(12'd2, 5'd2, 3'b000, 5'd6, 7'b1100111));
    prog.push_back(addi(5'd9, 5'd0, 12'd99));
    prog.push_back(addi(5'd9, 5'd0, 12'd99));
    prog.push_back(s_type(12'h204, 5'd6, 3'b010));
    prog.push_back(s_type(12'h208, 5'd9, 3'b010));
    expect_q.push_back(jal_at + 4);
    expect_q.push_back(jalr_at + 4);
    expect_q.push_back(32'd0);
    loop_at = (prog.size() + 1) * 4;
    end_program();
    run_until_marker("jump");
    repeat (3) @(posedge clk);
    check_results("jump");
    check_word("jump debug", 32'(loop_at >> 2), 32'(debug));
    finish_test("jump");
  endtask

  task automatic byte_test();
    logic [31:0] orig;
    logic [7:0]  val;
    orig = 32'h11223344;
    val = 8'ha5;
    clear_memory();
    mem0.mem[12'hc0] = orig;
    prog.push_back(addi(5'd2, 5'd0, {4'h0, val}));
    prog.push_back(s_type(12'h301, 5'd2, 3'b000));
    store_result(i_type(12'h300, 5'd0, 3'b010, 5'd3, 7'b0000011),
                 (orig & 32'hffff00ff) | {16'h0, val, 8'h0});
    store_result(i_type(12'h301, 5'd0, 3'b000, 5'd4, 7'b0000011), {{24{val[7]}}, val});
    store_result(i_type(12'h301, 5'd0, 3'b100, 5'd5, 7'b0000011), {24'h0, val});
    end_program();
    run_until_marker("byte");
    check_results("byte");
    finish_test("byte");
  endtask

  task automatic external_test();
    build_alu_program();
    mem0.ext_granted = 1'b0;
    mem0.stb_during_grant = 1'b0;
    fork
      run_until_marker("external");
      begin
        repeat (20) @(posedge clk);
        mem0.ext_write(30'h180, 32'hcafef00d);
      end
    join
    check_results("external");
    check_word("external word", 32'hcafef00d, mem0.mem[12'h180]);
    if (!mem0.ext_granted) begin
      $display("external: the external master was never granted the bus");
      test_errors++;
    end
    if (mem0.stb_during_grant) begin
      $display("external: stb_o was high while the external master held the bus");
      test_errors++;
    end
    finish_test("external");
  endtask

  task automatic reset_test();
    int   n;
    logic seen;
    logic alt_seen;
    clear_memory();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    check_word("reset stb", 32'd0, 32'(stb));
    check_word("reset we", 32'd0, 32'(we));
    check_word("reset grant", 32'd0, 32'(ctrl_grant));
    check_word("reset debug", 32'd0, 32'(debug));
    check_word("reset alt stb", 32'd0, 32'(alt_stb));
    check_word("reset alt we", 32'd0, 32'(alt_we));
    check_word("reset alt grant", 32'd0, 32'(alt_grant));
    check_word("reset alt debug", 32'h40 >> 2, 32'(alt_debug));
    #1 reset = 1'b0;
    n = 0;
    seen = 1'b0;
    alt_seen = 1'b0;
    while (!(seen && alt_seen) && n < 50) begin
      @(posedge clk);
      n++;
      if (stb && !seen) begin
        seen = 1'b1;
        check_word("reset first fetch", 32'h0, 32'(adr));
      end
      if (alt_stb && !alt_seen) begin
        alt_seen = 1'b1;
        check_word("reset first fetch alt", 32'h40 >> 2, 32'(alt_adr));
      end
    end
    if (!(seen && alt_seen)) begin
      $display("reset: no strobe appeared after reset was released");
      test_errors++;
    end
    finish_test("reset");
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    alu_test();
    branch_test();
    jump_test();
    byte_test();
    external_test();
    reset_test();
    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
common/rv_core_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_bus_arbiter.sv
hw/rv_lsu.sv
rv_core/rv_core_nopipe.sv
tb/tb_bus_memory.sv
tb/tb_rv_core.sv
